//--- verilog/stream_pkg.sv
/*
 * Shared types and constants for the byte stream frame filter.
 * Modules pull these in with a wildcard import in their headers.
 */

package stream_pkg;

    localparam int FIFO_DEPTH = 16;  // Entries in each stream FIFO.
    localparam int STAT_WIDTH = 16;  // Width of the statistics counters.

    // Header byte layout. The frame type sits in the upper nibble.
    localparam int TYPE_MSB = 7;
    localparam int TYPE_LSB = 4;

    // One data beat on the stream.
    typedef logic [7:0] byte_t;

    // Frame type field taken from the header beat.
    typedef logic [TYPE_MSB-TYPE_LSB:0] frame_type_t;

    // Statistics counter value.
    typedef logic [STAT_WIDTH-1:0] stat_cnt_t;

    // FIFO fill level, 0 up to FIFO_DEPTH inclusive.
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_t;

    // Frame position as seen by the header decoder.
    typedef enum logic {
        DEC_HEAD = 1'b0,  // Next beat starts a frame.
        DEC_BODY = 1'b1   // Inside a frame, header already seen.
    } decode_state_t;

endpackage

//--- verilog/axis_srl_fifo.sv
/*
 * Shift-register FIFO for an AXI4-Stream carrying data and last.
 * New beats shift in at entry 0, the head is picked by the fill pointer.
 * Ready and valid come straight from registered full and empty flags.
 */

`timescale 1ns/1ps

module axis_srl_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 16
) (
    input  logic                             clk,
    input  logic                             rst,

    input  logic [DATA_WIDTH-1:0]            s_tdata,
    input  logic                             s_tvalid,
    output logic                             s_tready,
    input  logic                             s_tlast,

    output logic [DATA_WIDTH-1:0]            m_tdata,
    output logic                             m_tvalid,
    input  logic                             m_tready,
    output logic                             m_tlast,

    output logic [$clog2(DEPTH+1)-1:0]       count
);

    localparam int PW = $clog2(DEPTH+1);               // Pointer width, holds 0..DEPTH.
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Entry index width.

    logic [DATA_WIDTH:0] mem [DEPTH];  // {last, data} per entry.

    logic [PW-1:0] ptr_q;              // Number of stored beats.
    logic [PW-1:0] ptr_m1;
    logic [AW-1:0] rd_idx;
    logic          full_q;
    logic          empty_q;

    logic          wr_en;
    logic          rd_en;

    assign s_tready = ~full_q;
    assign m_tvalid = ~empty_q;

    assign wr_en = s_tvalid & ~full_q;
    assign rd_en = m_tready & ~empty_q;

    // Oldest beat sits one below the fill pointer.
    assign ptr_m1 = ptr_q - 1'b1;
    assign rd_idx = ptr_m1[AW-1:0];

    assign m_tdata = mem[rd_idx][DATA_WIDTH-1:0];
    assign m_tlast = mem[rd_idx][DATA_WIDTH];

    assign count = ptr_q;

    // Pointer and flags.
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q   <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            if (wr_en && !rd_en) begin
                ptr_q   <= ptr_q + 1'b1;
                full_q  <= (ptr_q == PW'(DEPTH - 1));  // Last free slot taken.
                empty_q <= 1'b0;
            end else if (rd_en && !wr_en) begin
                ptr_q   <= ptr_m1;
                full_q  <= 1'b0;
                empty_q <= (ptr_q == PW'(1));          // Last beat leaves.
            end
            // Read with write shifts in place, level unchanged.
        end
    end

    // Storage shifts on every write.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[0] <= {s_tlast, s_tdata};
            for (int i = 1; i < DEPTH; i++) begin
                mem[i] <= mem[i-1];
            end
        end
    end

endmodule

//--- verilog/frame_header_decode.sv
/*
 * Header decoder for the frame filter.
 * Follows frame boundaries on the ingress stream and gives a pass/drop
 * verdict, combinational on the header beat and held for the body.
 */

`timescale 1ns/1ps

module frame_header_decode
    import stream_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  byte_t       fifo_tdata,
    input  logic        fifo_tlast,
    input  logic        fifo_fire,     // Beat transfer from the gate.

    input  frame_type_t drop_type,

    output logic        frame_pass
);

    decode_state_t state_q;

    logic        is_head;
    logic        head_pass;
    logic        pass_q;   // Verdict kept from the header.
    frame_type_t head_type;

    assign is_head   = (state_q == DEC_HEAD);
    assign head_type = fifo_tdata[TYPE_MSB:TYPE_LSB];
    assign head_pass = (head_type != drop_type);

    // On the header the verdict comes straight from the type nibble.
    assign frame_pass = is_head ? head_pass : pass_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DEC_HEAD;
            pass_q  <= 1'b0;
        end else if (fifo_fire) begin
            if (is_head) begin
                pass_q <= head_pass;  // Hold for the body beats.
            end

            // A single-beat frame goes straight back to DEC_HEAD.
            if (fifo_tlast) begin
                state_q <= DEC_HEAD;
            end else begin
                state_q <= DEC_BODY;
            end
        end
    end

endmodule

//--- verilog/frame_drop_gate.sv
/*
 * Execute stage of the frame filter.
 * Passed frames are steered to the egress FIFO with normal flow control.
 * Dropped frames are acknowledged here and never forwarded.
 * Also raises the frame and byte pulses for the statistics block.
 */

`timescale 1ns/1ps

module frame_drop_gate
    import stream_pkg::*;
(
    // From the ingress FIFO.
    input  byte_t fifo_tdata,
    input  logic  fifo_tvalid,
    input  logic  fifo_tlast,
    output logic  fifo_tready,
    output logic  fifo_fire,

    // Verdict from the decoder.
    input  logic  frame_pass,

    // Towards the egress FIFO.
    output byte_t gate_tdata,
    output logic  gate_tvalid,
    output logic  gate_tlast,
    input  logic  gate_tready,

    // Statistics pulses.
    output logic  frame_done,
    output logic  frame_passed,
    output logic  beat_passed
);

    logic pass_beat;  // Current beat belongs to a passed frame.

    assign pass_beat = fifo_tvalid & frame_pass;

    // Dropped beats are always accepted so they drain under back-pressure.
    assign fifo_tready = frame_pass ? gate_tready : 1'b1;
    assign fifo_fire   = fifo_tvalid & fifo_tready;

    assign gate_tdata  = fifo_tdata;
    assign gate_tlast  = fifo_tlast;
    assign gate_tvalid = pass_beat;

    // One pulse per completed frame, tagged with its verdict.
    assign frame_done   = fifo_fire & fifo_tlast;
    assign frame_passed = frame_pass;

    assign beat_passed  = fifo_fire & frame_pass;  // Written to egress.

endmodule

//--- verilog/frame_stats.sv
/*
 * Result counters for the frame filter.
 * Counts passed frames, dropped frames and passed bytes, saturating at
 * all ones. Each counter follows its pulse by one cycle.
 */

`timescale 1ns/1ps

module frame_stats
    import stream_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      frame_done,
    input  logic      frame_passed,
    input  logic      beat_passed,

    output stat_cnt_t passed_frames,
    output stat_cnt_t dropped_frames,
    output stat_cnt_t passed_bytes
);

    // Increment that sticks at the top value.
    function automatic stat_cnt_t sat_inc(input stat_cnt_t val);
        if (&val) begin
            return val;
        end
        return val + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            passed_frames  <= '0;
            dropped_frames <= '0;
            passed_bytes   <= '0;
        end else begin
            if (frame_done && frame_passed) begin
                passed_frames <= sat_inc(passed_frames);
            end
            if (frame_done && !frame_passed) begin
                dropped_frames <= sat_inc(dropped_frames);
            end
            if (beat_passed) begin
                passed_bytes <= sat_inc(passed_bytes);  // One byte per beat.
            end
        end
    end

endmodule

//--- verilog/frame_filter_top.sv
/*
 * Frame filter top level for an 8-bit AXI4-Stream.
 * Ingress FIFO, header decode, drop gate, egress FIFO and statistics.
 * Frames whose header type equals drop_type are discarded.
 */

`timescale 1ns/1ps

module frame_filter_top
    import stream_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  frame_type_t drop_type,

    input  byte_t       in_tdata,
    input  logic        in_tvalid,
    output logic        in_tready,
    input  logic        in_tlast,

    output byte_t       out_tdata,
    output logic        out_tvalid,
    input  logic        out_tready,
    output logic        out_tlast,

    output fifo_count_t in_count,
    output stat_cnt_t   passed_frames,
    output stat_cnt_t   dropped_frames,
    output stat_cnt_t   passed_bytes
);

    // Stream A from the ingress FIFO to the gate.
    byte_t fifo_tdata;
    logic  fifo_tvalid;
    logic  fifo_tready;
    logic  fifo_tlast;
    logic  fifo_fire;

    logic  frame_pass;

    // Stream B from the gate to the egress FIFO.
    byte_t gate_tdata;
    logic  gate_tvalid;
    logic  gate_tready;
    logic  gate_tlast;

    logic  frame_done;
    logic  frame_passed;
    logic  beat_passed;

    axis_srl_fifo #(
        .DATA_WIDTH ($bits(byte_t)),
        .DEPTH      (FIFO_DEPTH)
    ) u_ingress (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (in_tdata),
        .s_tvalid (in_tvalid),
        .s_tready (in_tready),
        .s_tlast  (in_tlast),
        .m_tdata  (fifo_tdata),
        .m_tvalid (fifo_tvalid),
        .m_tready (fifo_tready),
        .m_tlast  (fifo_tlast),
        .count    (in_count)
    );

    frame_header_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .fifo_tdata (fifo_tdata),
        .fifo_tlast (fifo_tlast),
        .fifo_fire  (fifo_fire),
        .drop_type  (drop_type),
        .frame_pass (frame_pass)
    );

    frame_drop_gate u_gate (
        .fifo_tdata   (fifo_tdata),
        .fifo_tvalid  (fifo_tvalid),
        .fifo_tlast   (fifo_tlast),
        .fifo_tready  (fifo_tready),
        .fifo_fire    (fifo_fire),
        .frame_pass   (frame_pass),
        .gate_tdata   (gate_tdata),
        .gate_tvalid  (gate_tvalid),
        .gate_tlast   (gate_tlast),
        .gate_tready  (gate_tready),
        .frame_done   (frame_done),
        .frame_passed (frame_passed),
        .beat_passed  (beat_passed)
    );

    axis_srl_fifo #(
        .DATA_WIDTH ($bits(byte_t)),
        .DEPTH      (FIFO_DEPTH)
    ) u_egress (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (gate_tdata),
        .s_tvalid (gate_tvalid),
        .s_tready (gate_tready),
        .s_tlast  (gate_tlast),
        .m_tdata  (out_tdata),
        .m_tvalid (out_tvalid),
        .m_tready (out_tready),
        .m_tlast  (out_tlast),
        .count    ()
    );

    frame_stats u_stats (
        .clk            (clk),
        .rst            (rst),
        .frame_done     (frame_done),
        .frame_passed   (frame_passed),
        .beat_passed    (beat_passed),
        .passed_frames  (passed_frames),
        .dropped_frames (dropped_frames),
        .passed_bytes   (passed_bytes)
    );

endmodule

//--- verification/tb_frame_filter.sv
/*
 * Testbench for the frame filter top level.
 * Random frames from a fixed xorshift seed go in, a reference model
 * predicts the output stream and the statistics counters.
 */

`timescale 1ns/1ps

module tb_frame_filter
    import stream_pkg::*;
();

    logic        clk;
    logic        rst;
    frame_type_t drop_type;
    byte_t       in_tdata;
    logic        in_tvalid;
    logic        in_tready;
    logic        in_tlast;
    byte_t       out_tdata;
    logic        out_tvalid;
    logic        out_tready;
    logic        out_tlast;
    fifo_count_t in_count;
    stat_cnt_t   passed_frames;
    stat_cnt_t   dropped_frames;
    stat_cnt_t   passed_bytes;

    logic [31:0] rng_state;
    logic [8:0]  src_q[$];     // Beats waiting to be sent, {last, data}.
    logic [8:0]  exp_q[$];     // Beats expected at the output.
    logic        in_fire;
    logic        gap_en;
    int          ready_mode;   // 0 always ready, 1 random, 2 stalled.
    logic        model_head;
    logic        model_pass;
    stat_cnt_t   exp_frames;
    stat_cnt_t   exp_drops;
    stat_cnt_t   exp_bytes;
    int          data_errs;
    int          count_errs;
    int          level_errs;
    int          flag_errs;
    int          timeouts;

    frame_filter_top DUT (
        .clk            (clk),
        .rst            (rst),
        .drop_type      (drop_type),
        .in_tdata       (in_tdata),
        .in_tvalid      (in_tvalid),
        .in_tready      (in_tready),
        .in_tlast       (in_tlast),
        .out_tdata      (out_tdata),
        .out_tvalid     (out_tvalid),
        .out_tready     (out_tready),
        .out_tlast      (out_tlast),
        .in_count       (in_count),
        .passed_frames  (passed_frames),
        .dropped_frames (dropped_frames),
        .passed_bytes   (passed_bytes)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_byte(input byte_t got, input logic got_last,
                              input byte_t exp, input logic exp_last);
        if (got !== exp || got_last !== exp_last) begin
            data_errs++;
            $display("ERR %0t: output byte %02h last %0b, expected %02h last %0b",
                     $time, got, got_last, exp, exp_last);
        end
    endtask

    task automatic check_count(input stat_cnt_t got, input stat_cnt_t exp, input string label);
        if (got !== exp) begin
            count_errs++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, label, got, exp);
        end
    endtask

    task automatic check_level(input fifo_count_t got, input fifo_count_t exp,
                               input string label);
        if (got !== exp) begin
            level_errs++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, label, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string label);
        if (got !== exp) begin
            flag_errs++;
            $display("ERR %0t: %s is %0b, expected %0b", $time, label, got, exp);
        end
    endtask

    // Filter rule applied to each accepted input beat.
    task automatic model_accept(input byte_t data, input logic last);
        if (model_head) begin
            model_pass = (data[TYPE_MSB:TYPE_LSB] != drop_type);
        end
        if (model_pass) begin
            exp_q.push_back({last, data});
            exp_bytes = exp_bytes + 1'b1;
        end
        if (last && model_pass) begin
            exp_frames = exp_frames + 1'b1;
        end else if (last) begin
            exp_drops = exp_drops + 1'b1;
        end
        model_head = last;  // Next beat after last is a header.
    endtask

    // One clock cycle. Drive at the falling edge, sample 1 ns later.
    task automatic tick();
        logic [31:0] r;
        logic [8:0]  want;
        @(negedge clk);
        if (in_fire) begin
            void'(src_q.pop_front());
            in_tvalid = 1'b0;
        end
        r = rand_next();
        if (!in_tvalid && src_q.size() > 0 && (!gap_en || r[1:0] != 2'b00)) begin
            in_tvalid = 1'b1;
            in_tdata  = src_q[0][7:0];
            in_tlast  = src_q[0][8];
        end
        case (ready_mode)
            0:       out_tready = 1'b1;
            1:       out_tready = r[9] | r[10];  // Ready about three cycles in four.
            default: out_tready = 1'b0;
        endcase
        #1;
        in_fire = in_tvalid & in_tready;
        if (in_fire) begin
            model_accept(in_tdata, in_tlast);
        end
        if (out_tvalid && out_tready) begin
            if (exp_q.size() == 0) begin
                data_errs++;
                $display("ERR %0t: output byte %02h with nothing expected", $time, out_tdata);
            end else begin
                want = exp_q.pop_front();
                check_byte(out_tdata, out_tlast, want[7:0], want[8]);
            end
        end
    endtask

    task automatic queue_frame(input int len, input frame_type_t ftype);
        logic [31:0] r;
        r = rand_next();
        src_q.push_back({(len == 1), ftype, r[3:0]});
        for (int i = 1; i < len; i++) begin
            r = rand_next();
            src_q.push_back({(i == len - 1), r[7:0]});
        end
    endtask

    task automatic queue_random(input int frames);
        logic [31:0] r;
        for (int f = 0; f < frames; f++) begin
            r = rand_next();
            // About one frame in four carries the dropped type.
            queue_frame(1 + int'(r[7:0] % 8'd12), (r[9:8] == 2'b00) ? drop_type : r[15:12]);
        end
    endtask

    function automatic logic drained();
        return src_q.size() == 0 && !in_tvalid && in_count == '0 && !out_tvalid
               && exp_q.size() == 0;
    endfunction

    task automatic wait_sent(input int limit);
        int n;
        n = 0;
        while ((src_q.size() > 0 || in_tvalid) && n < limit) begin
            tick();
            n++;
        end
        if (src_q.size() > 0 || in_tvalid) begin
            timeouts++;
            $display("Timeout: input beats were still waiting after %0d cycles", limit);
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (!drained() && n < limit) begin
            tick();
            n++;
        end
        if (!drained()) begin
            timeouts++;
            $display("Timeout: the filter did not drain within %0d cycles", limit);
        end
        tick();
    endtask

    task automatic wait_in_stall(input int limit);
        int n;
        n = 0;
        while (in_tready && n < limit) begin
            tick();
            n++;
        end
        if (in_tready) begin
            timeouts++;
            $display("Timeout: in_tready stayed high for %0d cycles with the sink stalled", limit);
        end
    endtask

    initial begin
        rst        = 1'b1;
        drop_type  = 4'h3;
        in_tdata   = '0;
        in_tvalid  = 1'b0;
        in_tlast   = 1'b0;
        out_tready = 1'b0;
        rng_state  = 32'h21b3;
        in_fire    = 1'b0;
        gap_en     = 1'b1;
        ready_mode = 0;
        model_head = 1'b1;
        model_pass = 1'b0;
        exp_frames = '0;
        exp_drops  = '0;
        exp_bytes  = '0;
        data_errs  = 0;
        count_errs = 0;
        level_errs = 0;
        flag_errs  = 0;
        timeouts   = 0;

        repeat (10) @(negedge clk);
        rst = 1'b0;
        #1;
        check_flag(out_tvalid, 1'b0, "out_tvalid after reset");
        check_flag(in_tready, 1'b1, "in_tready after reset");
        check_level(in_count, '0, "in_count after reset");
        check_count(passed_frames, '0, "passed_frames after reset");
        check_count(dropped_frames, '0, "dropped_frames after reset");
        check_count(passed_bytes, '0, "passed_bytes after reset");

        // Sink always ready.
        queue_random(20);
        wait_sent(2000);
        wait_drain(500);

        // Random sink back-pressure.
        ready_mode = 1;
        queue_random(30);
        wait_sent(4000);
        wait_drain(1000);

        // Stalled sink, enough passed beats to fill both FIFOs.
        gap_en     = 1'b0;
        ready_mode = 2;
        repeat (3) queue_frame(12, 4'h5);
        wait_in_stall(200);
        check_level(in_count, fifo_count_t'(FIFO_DEPTH), "in_count with sink stalled");
        ready_mode = 0;
        wait_sent(500);
        wait_drain(500);

        // Single-beat frames and back-to-back frames without gaps.
        for (int t = 0; t < 16; t++) begin
            queue_frame(1, frame_type_t'(t));
        end
        queue_frame(3, drop_type);
        queue_frame(1, drop_type);
        queue_frame(2, 4'h9);
        wait_sent(500);
        wait_drain(500);

        // New drop type, only changed while idle.
        @(negedge clk);
        drop_type  = 4'hA;
        gap_en     = 1'b1;
        ready_mode = 1;
        queue_frame(4, 4'h3);
        queue_frame(4, 4'hA);
        queue_random(25);
        wait_sent(4000);
        wait_drain(1000);

        check_count(passed_frames, exp_frames, "passed_frames");
        check_count(dropped_frames, exp_drops, "dropped_frames");
        check_count(passed_bytes, exp_bytes, "passed_bytes");

        $display("Errors: data %0d, count %0d, level %0d, flag %0d, timeout %0d",
                 data_errs, count_errs, level_errs, flag_errs, timeouts);
        if (data_errs + count_errs + level_errs + flag_errs + timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- project.f
verilog/stream_pkg.sv
verilog/axis_srl_fifo.sv
verilog/frame_header_decode.sv
verilog/frame_drop_gate.sv
verilog/frame_stats.sv
verilog/frame_filter_top.sv
verification/tb_frame_filter.sv

//--- run_sim.sh
#!/bin/sh
# Build the frame filter testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f project.f --top-module tb_frame_filter -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_frame_filter" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0
